// File: tb.f
verilog/conv_pkg.sv
verilog/conv_loop_seq.sv
verilog/block_job_queue.sv
verilog/block_engine.sv
verilog/conv_ctrl_top.sv
verification/tb_clkgen.sv
verification/conv_ctrl_checker.sv
verification/conv_ctrl_tb.sv

// File: Makefile
TOOL       = verilator
TOP        = conv_ctrl_tb
FILELIST   = tb.f
FLAGS      = --binary --timing -Wno-fatal --top-module $(TOP)
LINT_FLAGS = --lint-only --timing -Wall --top-module $(TOP)
OBJ_DIR    = obj_dir
LOG        = sim.log

.PHONY: all lint sim clean

all: sim

lint:
	$(TOOL) $(LINT_FLAGS) -f $(FILELIST)

sim:
	$(TOOL) $(FLAGS) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "SIMULATION FAILED" $(LOG); then echo "run reported failure"; exit 1; fi
	@grep -q "SIMULATION PASSED" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: verification/conv_ctrl_tb.sv
`timescale 1ns/1ns
`default_nettype none

module conv_ctrl_tb import conv_pkg::*; ();

    localparam int n_tests   = 8;
    localparam int pipe_lat  = 5;
    localparam int job_depth = 4;

    logic      clk;
    logic      rst;
    conv_cfg_t cfg;
    logic      start;
    buf_rd_t   buf_rd;
    buf_wr_t   buf_wr;
    pea_ctrl_t pea;
    logic      done;
    int        err_count;
    int        test_count;
    int        budget;
    int        seed;
    logic      running;     // high while a layer is in flight

    tb_clkgen #(
        .half_period  (4),
        .reset_cycles (2)
    ) tb_clkgen_inst (
        .clk (clk),
        .rst (rst)
    );

    conv_ctrl_top #(
        .pipe_lat  (pipe_lat),
        .job_depth (job_depth)
    ) conv_ctrl_top_inst (
        .clk    (clk),
        .rst    (rst),
        .cfg    (cfg),
        .start  (start),
        .buf_rd (buf_rd),
        .buf_wr (buf_wr),
        .pea    (pea),
        .done   (done)
    );

    conv_ctrl_checker conv_ctrl_checker_inst (
        .clk        (clk),
        .rst        (rst),
        .cfg        (cfg),
        .start      (start),
        .buf_rd     (buf_rd),
        .buf_wr     (buf_wr),
        .pea        (pea),
        .done       (done),
        .err_count  (err_count),
        .test_count (test_count),
        .budget     (budget)
    );

    function automatic int pick(input int lo, input int hi);
        return lo + int'($unsigned($random(seed)) % (hi - lo + 1));
    endfunction

    function automatic conv_cfg_t make_cfg(input int dw, input int dh, input int ch,
                                           input int fn, input int fw, input int fh);
        conv_cfg_t c;
        c.data_wid   = dim_t'(dw);
        c.data_hei   = dim_t'(dh);
        c.data_ch    = dim_t'(ch);
        c.filter_num = dim_t'(fn);
        c.filter_wid = dim_t'(fw);
        c.filter_hei = dim_t'(fh);
        return c;
    endfunction

    task automatic run_layer(input conv_cfg_t c);
        @(negedge clk);
        cfg   = c;
        start = 1'b1;
        @(negedge clk);
        start   = 1'b0;
        running = 1'b1;
        while (!done) @(negedge clk);
        running = 1'b0;
        repeat (3) @(negedge clk);
    endtask

    //////////////////////////////////////////////////////////////////////
    // stimulus
    //////////////////////////////////////////////////////////////////////

    initial begin : stimulus
        seed    = 32'h2eff00fb;
        cfg     = '0;
        start   = 1'b0;
        running = 1'b0;
        wait (rst == 1'b0);
        repeat (4) @(negedge clk);              // quiet, outputs must stay low
        run_layer(make_cfg(5, 4, 5, 6, 2, 3));  // partial blocks on both loops
        run_layer(make_cfg(4, 4, 4, 8, 3, 3));
        for (int t = 2; t < n_tests; t++) begin
            run_layer(make_cfg(pick(3, 8), pick(3, 8), pick(1, 10), pick(1, 10),
                               pick(1, 3), pick(1, 3)));
        end
        repeat (4) @(negedge clk);
        $display("%0d of %0d tests run, %0d errors", test_count, n_tests, err_count);
        if (err_count == 0 && test_count == n_tests) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

    // budget per layer comes from the expected event counts
    initial begin : watchdog
        int cycles;
        cycles = 0;
        while (!(running && cycles > budget)) begin
            @(posedge clk);
            cycles = running ? cycles + 1 : 0;
        end
        $display("timeout: test %0d saw no done within %0d cycles", test_count, budget);
        $display("SIMULATION FAILED");
        $finish;
    end

endmodule

`default_nettype wire

// File: verification/conv_ctrl_checker.sv
`timescale 1ns/1ns
`default_nettype none

module conv_ctrl_checker import conv_pkg::*; (
    input  logic      clk,
    input  logic      rst,
    input  conv_cfg_t cfg,
    input  logic      start,
    input  buf_rd_t   buf_rd,
    input  buf_wr_t   buf_wr,
    input  pea_ctrl_t pea,
    input  logic      done,
    output int        err_count,
    output int        test_count,
    output int        budget
);

    localparam int k_kernel = 0;
    localparam int k_bias   = 1;
    localparam int k_pixel  = 2;

    typedef logic [addr_w-1:0] addr_t;

    typedef struct packed {
        logic [1:0]       kind;     // kernel word, bias or input pixel
        logic [row_w-1:0] row;
        buf_rd_t          rd;
    } rd_event_t;

    rd_event_t        rd_q[$];
    buf_wr_t          wr_q[$];
    lane_mask_t       mac_q[$];
    logic             active;
    int               base_err;
    lane_mask_t       exp_sf;       // strobes owed by last cycle's read
    lane_mask_t       exp_sb;
    lane_mask_t       exp_sl;
    logic [row_w-1:0] exp_row;

    function automatic lane_mask_t lanes_used(input int n);
        int rem;
        rem = n % n_pe;
        return (rem == 0) ? '1 : lane_mask_t'((1 << rem) - 1);
    endfunction

    function automatic rd_event_t read_event(input int kind, input int row,
                                             input lane_mask_t mask, input logic bias,
                                             input int addr);
        rd_event_t e;
        e.kind       = 2'(kind);
        e.row        = row_w'(row);
        e.rd.en_mask = mask;
        e.rd.is_bias = bias;
        e.rd.addr    = addr_t'(addr);
        return e;
    endfunction

    //////////////////////////////////////////////////////////////////////
    // reference model that fills the expected lists and returns a cycle budget
    //////////////////////////////////////////////////////////////////////

    function automatic int build_expected(input conv_cfg_t c);
        int         fsz;
        int         isz;
        int         osz;
        int         fill;
        int         fbn;
        int         cbn;
        int         rows;
        int         n_ev;
        lane_mask_t fm;
        lane_mask_t cm;
        buf_wr_t    w;
        fsz  = int'(c.filter_wid) * int'(c.filter_hei);
        isz  = int'(c.data_wid) * int'(c.data_hei);
        osz  = (int'(c.data_wid) - int'(c.filter_wid) + 1)
               * (int'(c.data_hei) - int'(c.filter_hei) + 1);
        fill = (int'(c.filter_hei) - 1) * int'(c.data_wid) + int'(c.filter_wid);
        fbn  = (int'(c.filter_num) + n_pe - 1) / n_pe;
        cbn  = (int'(c.data_ch) + n_pe - 1) / n_pe;
        n_ev = 0;
        for (int fb = 0; fb < fbn; fb++) begin
            fm   = (fb == fbn - 1) ? lanes_used(int'(c.filter_num)) : '1;
            rows = $countones(fm);
            for (int cb = 0; cb < cbn; cb++) begin
                cm = (cb == cbn - 1) ? lanes_used(int'(c.data_ch)) : '1;
                for (int f = 0; f < rows; f++) begin
                    for (int k = 0; k < fsz; k++) begin
                        rd_q.push_back(read_event(k_kernel, f, cm, 1'b0,
                            isz * cbn + cb * fsz * int'(c.filter_num)
                            + fsz * (n_pe * fb + f) + k));
                    end
                    if (cb == cbn - 1) begin
                        rd_q.push_back(read_event(k_bias, f, cm, 1'b1, n_pe * fb + f));
                    end
                end
                for (int i = 0; i < isz; i++) begin
                    rd_q.push_back(read_event(k_pixel, 0, cm, 1'b0, isz * cb + i));
                end
                for (int m = fill; m < isz; m++) begin
                    mac_q.push_back(cm);
                end
                for (int k = 0; k < osz; k++) begin
                    w.en_mask = fm;
                    w.addr    = addr_t'(osz * fb + k);
                    wr_q.push_back(w);
                end
                n_ev += rows * (fsz + 2) + isz + osz;
            end
        end
        return 2 * n_ev + 40 * fbn * cbn + 100;
    endfunction

    task automatic report_error(input string msg);
        $display("ERROR at %0t ns: %s", $time, msg);
        err_count++;
    endtask

    task automatic compare_value(input string name, input logic [31:0] got,
                                 input logic [31:0] exp);
        if (got !== exp) begin
            $display("FAILED %s: got %h, expected %h at %0t ns", name, got, exp, $time);
            err_count++;
        end
    endtask

    task automatic close_test();
        if (!active) begin
            report_error("done pulsed while no layer was running");
        end else begin
            if (rd_q.size() != 0 || mac_q.size() != 0 || wr_q.size() != 0) begin
                report_error($sformatf("done came early, %0d reads %0d macs %0d writes left",
                                       rd_q.size(), mac_q.size(), wr_q.size()));
            end
            $display("test %0d finished with %0d errors", test_count, err_count - base_err);
            test_count++;
            active = 1'b0;
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // in-order compare on the rising edge
    //////////////////////////////////////////////////////////////////////

    always @(posedge clk) begin : compare
        rd_event_t e;
        if (rst) begin
            err_count  = 0;
            test_count = 0;
            budget     = 0;
            active     = 1'b0;
            exp_sf     = '0;
            exp_sb     = '0;
            exp_sl     = '0;
            exp_row    = '0;
            rd_q.delete();
            wr_q.delete();
            mac_q.delete();
        end else begin
            compare_value("pea.shift_filter", 32'(pea.shift_filter), 32'(exp_sf));
            if (exp_sf != '0) begin
                compare_value("pea.shift_filter_row", 32'(pea.shift_filter_row), 32'(exp_row));
            end
            compare_value("pea.shift_bias", 32'(pea.shift_bias), 32'(exp_sb));
            compare_value("pea.shift_line", 32'(pea.shift_line), 32'(exp_sl));
            exp_sf = '0;
            exp_sb = '0;
            exp_sl = '0;
            if (start) begin
                budget   = build_expected(cfg);
                base_err = err_count;
                active   = 1'b1;
            end
            if (buf_rd.en_mask != '0) begin
                if (rd_q.size() == 0) begin
                    report_error($sformatf("read at address %h was not expected", buf_rd.addr));
                end else begin
                    e = rd_q.pop_front();
                    compare_value("buf_rd", 32'(buf_rd), 32'(e.rd));
                    case (int'(e.kind))
                        k_kernel: begin
                            exp_sf  = e.rd.en_mask;
                            exp_row = e.row;
                        end
                        k_bias:  exp_sb = lane_mask_t'(1) << e.row;    // one bit per row
                        default: exp_sl = e.rd.en_mask;
                    endcase
                end
            end
            if (pea.mac_enable != '0) begin
                if (mac_q.size() == 0) begin
                    report_error("mac_enable raised with no MAC cycle expected");
                end else begin
                    compare_value("pea.mac_enable", 32'(pea.mac_enable), 32'(mac_q.pop_front()));
                end
            end
            if (buf_wr.en_mask != '0) begin
                if (wr_q.size() == 0) begin
                    report_error($sformatf("write at address %h was not expected", buf_wr.addr));
                end else begin
                    compare_value("buf_wr", 32'(buf_wr), 32'(wr_q.pop_front()));
                end
            end
            if (done) begin
                close_test();
            end
        end
    end

endmodule

`default_nettype wire

// File: verification/tb_clkgen.sv
`timescale 1ns/1ns
`default_nettype none

module tb_clkgen #(
    parameter int half_period  = 4,
    parameter int reset_cycles = 2
) (
    output logic clk,
    output logic rst
);

    initial begin
        clk = 1'b0;
        forever #(half_period) clk = ~clk;
    end

    initial begin
        rst = 1'b1;
        repeat (reset_cycles) @(negedge clk);   // released on a falling edge
        rst = 1'b0;
    end

endmodule

`default_nettype wire

// File: verilog/conv_ctrl_top.sv
`timescale 1ns/1ns
`default_nettype none

module conv_ctrl_top import conv_pkg::*; #(
    parameter int pipe_lat  = 5,    // MAC to write-back
    parameter int job_depth = 4
) (
    input  logic      clk,
    input  logic      rst,
    input  conv_cfg_t cfg,
    input  logic      start,
    output buf_rd_t   buf_rd,
    output buf_wr_t   buf_wr,
    output pea_ctrl_t pea,
    output logic      done
);

    // sequencer to queue
    logic       job_req;
    block_job_t job_in;
    logic       job_ack;

    // queue to engine
    logic       head_req;
    block_job_t head;
    logic       head_ack;

    conv_loop_seq conv_loop_seq_inst (
        .clk     (clk),
        .rst     (rst),
        .cfg     (cfg),
        .start   (start),
        .job_req (job_req),
        .job_in  (job_in),
        .job_ack (job_ack)
    );

    block_job_queue #(
        .job_depth (job_depth)
    ) block_job_queue_inst (
        .clk      (clk),
        .rst      (rst),
        .job_req  (job_req),
        .job_in   (job_in),
        .job_ack  (job_ack),
        .head_req (head_req),
        .head     (head),
        .head_ack (head_ack)
    );

    block_engine #(
        .pipe_lat (pipe_lat)
    ) block_engine_inst (
        .clk      (clk),
        .rst      (rst),
        .cfg      (cfg),
        .head_req (head_req),
        .head     (head),
        .head_ack (head_ack),
        .buf_rd   (buf_rd),
        .buf_wr   (buf_wr),
        .pea      (pea),
        .done     (done)
    );

endmodule

`default_nettype wire

// File: verilog/block_engine.sv
`timescale 1ns/1ns
`default_nettype none

module block_engine import conv_pkg::*; #(
    parameter int pipe_lat = 5
) (
    input  logic       clk,
    input  logic       rst,
    input  conv_cfg_t  cfg,
    input  logic       head_req,
    input  block_job_t head,
    output logic       head_ack,
    output buf_rd_t    buf_rd,
    output buf_wr_t    buf_wr,
    output pea_ctrl_t  pea,
    output logic       done
);

    typedef logic [addr_w-1:0] addr_t;

    typedef enum logic [1:0] {
        e_idle,
        e_filt,     // filter push
        e_input     // input stream
    } eng_state_t;

    eng_state_t       state;
    block_job_t       job;
    logic [row_w-1:0] f_row;
    addr_t            kern_idx;
    addr_t            rd_idx;
    addr_t            mac_lat;
    addr_t            mac_idx;
    addr_t            wr_lat;
    addr_t            wr_idx;
    addr_t            slot;         // column slot for the write gate
    logic [row_w-1:0] sh_row;
    lane_mask_t       sh_filter;
    lane_mask_t       sh_bias;
    lane_mask_t       sh_line;

    addr_t filter_size;
    addr_t input_size;
    addr_t out_wid;
    addr_t out_hei;
    addr_t out_size;
    addr_t fill_lat;
    addr_t mac_cnt;
    addr_t wr_start;
    addr_t slot_last;
    addr_t chan_base;
    addr_t filt_end;
    addr_t row_num;
    logic  take;
    logic  row_last;
    logic  filt_rd;
    logic  bias_rd;
    logic  rd_on;
    logic  mac_on;
    logic  wr_on;

    //////////////////////////////////////////////////////////////////////
    // layer geometry, no padding and unit stride
    //////////////////////////////////////////////////////////////////////

    assign filter_size = cfg.filter_wid * cfg.filter_hei;
    assign input_size  = cfg.data_wid * cfg.data_hei;
    assign out_wid     = cfg.data_wid - cfg.filter_wid + 16'd1;
    assign out_hei     = cfg.data_hei - cfg.filter_hei + 16'd1;
    assign out_size    = out_wid * out_hei;
    assign fill_lat    = (cfg.filter_hei - 16'd1) * cfg.data_wid + cfg.filter_wid;
    assign mac_cnt     = input_size - fill_lat;
    assign wr_start    = fill_lat + addr_t'(pipe_lat);
    assign slot_last   = out_wid + cfg.filter_wid - 16'd2;
    assign chan_base   = input_size * addr_t'(blocks_of(cfg.data_ch));  // kernels follow inputs

    assign filt_end = filter_size + addr_t'(job.last_cb);   // last step is the idle cycle
    assign row_num  = addr_t'(job.fb) * addr_t'(n_pe) + addr_t'(f_row);
    // active rows are contiguous from row 0
    assign row_last = ((job.f_mask >> f_row) >> 1) == '0;

    assign take    = (state == e_idle) && head_req && !head_ack;
    assign filt_rd = (state == e_filt) && (kern_idx < filter_size);
    assign bias_rd = (state == e_filt) && (kern_idx == filter_size) && job.last_cb;
    assign rd_on   = (state == e_input) && (rd_idx < input_size);
    assign mac_on  = (state == e_input) && (mac_lat == fill_lat) && (mac_idx < mac_cnt);
    assign wr_on   = (state == e_input) && (wr_lat == wr_start) && (slot < out_wid)
                     && (wr_idx < out_size);

    always_ff @(posedge clk) begin
        if (take) begin
            job <= head;
        end
    end

    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            state     <= e_idle;
            head_ack  <= 1'b0;
            done      <= 1'b0;
            f_row     <= '0;
            kern_idx  <= '0;
            rd_idx    <= '0;
            mac_lat   <= '0;
            mac_idx   <= '0;
            wr_lat    <= '0;
            wr_idx    <= '0;
            slot      <= '0;
            sh_row    <= '0;
            sh_filter <= '0;
            sh_bias   <= '0;
            sh_line   <= '0;
        end else begin
            done      <= 1'b0;
            // PE shifts trail their buffer reads by one cycle
            sh_row    <= filt_rd ? f_row : '0;
            sh_filter <= filt_rd ? job.c_mask : '0;
            sh_bias   <= bias_rd ? (lane_mask_t'(1'b1) << f_row) : '0;
            sh_line   <= rd_on ? job.c_mask : '0;
            if (head_ack && !head_req) begin
                head_ack <= 1'b0;
            end
            case (state)
                e_idle: begin
                    if (take) begin
                        head_ack <= 1'b1;
                        f_row    <= '0;
                        kern_idx <= '0;
                        state    <= e_filt;
                    end
                end
                e_filt: begin
                    if (kern_idx == filt_end) begin
                        kern_idx <= '0;
                        if (row_last) begin
                            rd_idx  <= '0;
                            mac_lat <= '0;
                            mac_idx <= '0;
                            wr_lat  <= '0;
                            wr_idx  <= '0;
                            slot    <= '0;
                            state   <= e_input;
                        end else begin
                            f_row <= f_row + 1'b1;
                        end
                    end else begin
                        kern_idx <= kern_idx + 1'b1;
                    end
                end
                e_input: begin
                    if (rd_on) begin
                        rd_idx <= rd_idx + 1'b1;
                    end
                    if (mac_lat != fill_lat) begin
                        mac_lat <= mac_lat + 1'b1;      // window fill
                    end else if (mac_on) begin
                        mac_idx <= mac_idx + 1'b1;
                    end
                    if (wr_lat != wr_start) begin
                        wr_lat <= wr_lat + 1'b1;
                    end else begin
                        slot <= (slot == slot_last) ? '0 : slot + 1'b1;
                        if (wr_on) begin
                            wr_idx <= wr_idx + 1'b1;
                            if (wr_idx == out_size - 16'd1) begin
                                state <= e_idle;
                                done  <= job.last;  // end of layer
                            end
                        end
                    end
                end
                default: state <= e_idle;
            endcase
        end
    end

    //////////////////////////////////////////////////////////////////////
    // buffer ports and PE strobes
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        buf_rd = '0;
        if (filt_rd) begin
            buf_rd.en_mask = job.c_mask;
            buf_rd.addr    = chan_base + addr_t'(job.cb) * filter_size * cfg.filter_num
                             + filter_size * row_num + kern_idx;
        end else if (bias_rd) begin
            buf_rd.en_mask = job.c_mask;
            buf_rd.is_bias = 1'b1;
            buf_rd.addr    = row_num;
        end else if (rd_on) begin
            buf_rd.en_mask = job.c_mask;
            buf_rd.addr    = input_size * addr_t'(job.cb) + rd_idx;
        end
    end

    always_comb begin
        buf_wr = '0;
        if (wr_on) begin
            buf_wr.en_mask = job.f_mask;
            buf_wr.addr    = out_size * addr_t'(job.fb) + wr_idx;
        end
    end

    always_comb begin
        pea.shift_filter_row = sh_row;
        pea.shift_filter     = sh_filter;
        pea.shift_bias       = sh_bias;
        pea.shift_line       = sh_line;
        pea.mac_enable       = mac_on ? job.c_mask : '0;
    end

endmodule

`default_nettype wire

// File: verilog/block_job_queue.sv
`timescale 1ns/1ns
`default_nettype none

module block_job_queue import conv_pkg::*; #(
    parameter int job_depth = 4
) (
    input  logic       clk,
    input  logic       rst,
    input  logic       job_req,
    input  block_job_t job_in,
    output logic       job_ack,
    output logic       head_req,
    output block_job_t head,
    input  logic       head_ack
);

    localparam int ptr_w = (job_depth > 1) ? $clog2(job_depth) : 1;
    localparam int cnt_w = $clog2(job_depth + 1);

    typedef enum logic [1:0] {
        q_idle,
        q_req,
        q_rel
    } out_state_t;

    block_job_t       mem [job_depth];
    logic [ptr_w-1:0] wr_ptr;
    logic [ptr_w-1:0] rd_ptr;
    logic [cnt_w-1:0] count;
    logic             full;
    logic             push;
    logic             pop;
    out_state_t       out_state;

    assign full = (count == cnt_w'(job_depth));
    assign push = job_req && !job_ack && !full;     // ack stays low while full
    assign pop  = (out_state == q_req) && head_ack;

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= job_in;
        end
    end

    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            job_ack   <= 1'b0;
            out_state <= q_idle;
            wr_ptr    <= '0;
            rd_ptr    <= '0;
            count     <= '0;
        end else begin
            // write side
            if (push) begin
                job_ack <= 1'b1;
                wr_ptr  <= (wr_ptr == ptr_w'(job_depth - 1)) ? '0 : wr_ptr + 1'b1;
            end else if (!job_req) begin
                job_ack <= 1'b0;
            end
            // read side
            case (out_state)
                q_idle:  if (count != '0) out_state <= q_req;
                q_req:   if (head_ack) out_state <= q_rel;
                q_rel:   if (!head_ack) out_state <= q_idle;
                default: out_state <= q_idle;
            endcase
            if (pop) begin
                rd_ptr <= (rd_ptr == ptr_w'(job_depth - 1)) ? '0 : rd_ptr + 1'b1;
            end
            if (push && !pop) begin
                count <= count + 1'b1;
            end else if (pop && !push) begin
                count <= count - 1'b1;
            end
        end
    end

    assign head_req = (out_state == q_req);
    assign head     = mem[rd_ptr];

endmodule

`default_nettype wire

// File: verilog/conv_loop_seq.sv
`timescale 1ns/1ns
`default_nettype none

module conv_loop_seq import conv_pkg::*; (
    input  logic       clk,
    input  logic       rst,
    input  conv_cfg_t  cfg,
    input  logic       start,
    output logic       job_req,
    output block_job_t job_in,
    input  logic       job_ack
);

    typedef enum logic [1:0] {
        s_idle,
        s_req,     // req high, waiting for ack
        s_rel      // req low, waiting for ack to drop
    } seq_state_t;

    seq_state_t state;
    logic [7:0] fb;
    logic [7:0] cb;
    logic [7:0] fb_cnt;
    logic [7:0] cb_cnt;
    logic       fb_last;
    logic       cb_last;

    assign fb_cnt  = blocks_of(cfg.filter_num);
    assign cb_cnt  = blocks_of(cfg.data_ch);
    assign fb_last = (fb == fb_cnt - 8'd1);
    assign cb_last = (cb == cb_cnt - 8'd1);

    //////////////////////////////////////////////////////////////////////
    // block walk, filter blocks outer and channel blocks inner
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            state <= s_idle;
            fb    <= '0;
            cb    <= '0;
        end else begin
            case (state)
                s_idle: begin
                    if (start) begin
                        fb    <= '0;
                        cb    <= '0;
                        state <= s_req;
                    end
                end
                s_req: begin
                    if (job_ack) begin
                        state <= s_rel;
                    end
                end
                s_rel: begin
                    if (!job_ack) begin
                        if (fb_last && cb_last) begin
                            state <= s_idle;    // whole layer issued
                        end else begin
                            state <= s_req;
                            if (cb_last) begin
                                cb <= '0;
                                fb <= fb + 8'd1;
                            end else begin
                                cb <= cb + 8'd1;
                            end
                        end
                    end
                end
                default: state <= s_idle;
            endcase
        end
    end

    assign job_req = (state == s_req);

    // counters only move while req is low, so the job is stable under req
    always_comb begin
        job_in.fb      = fb;
        job_in.cb      = cb;
        job_in.f_mask  = fb_last ? edge_mask(cfg.filter_num) : '1;
        job_in.c_mask  = cb_last ? edge_mask(cfg.data_ch) : '1;
        job_in.last_cb = cb_last;
        job_in.last    = fb_last && cb_last;
    end

endmodule

`default_nettype wire

// File: verilog/conv_pkg.sv
`default_nettype none

package conv_pkg;

    localparam int n_pe   = 4;              // PE rows and lanes per block
    localparam int row_w  = $clog2(n_pe);
    localparam int addr_w = 16;

    typedef logic [15:0]     dim_t;
    typedef logic [n_pe-1:0] lane_mask_t;

    typedef struct packed {
        dim_t data_wid;
        dim_t data_hei;
        dim_t data_ch;
        dim_t filter_num;
        dim_t filter_wid;
        dim_t filter_hei;
    } conv_cfg_t;

    typedef struct packed {
        logic [7:0] fb;
        logic [7:0] cb;
        lane_mask_t f_mask;                 // filter rows in use
        lane_mask_t c_mask;                 // channel lanes in use
        logic       last_cb;
        logic       last;
    } block_job_t;

    typedef struct packed {
        lane_mask_t        en_mask;
        logic              is_bias;
        logic [addr_w-1:0] addr;
    } buf_rd_t;

    typedef struct packed {
        lane_mask_t        en_mask;
        logic [addr_w-1:0] addr;
    } buf_wr_t;

    typedef struct packed {
        logic [row_w-1:0] shift_filter_row;
        lane_mask_t       shift_filter;
        lane_mask_t       shift_bias;       // one bit per row
        lane_mask_t       shift_line;
        lane_mask_t       mac_enable;
    } pea_ctrl_t;

    // number of n_pe wide blocks, rounded up
    function automatic logic [7:0] blocks_of(input dim_t n);
        return 8'((32'(n) + n_pe - 1) / n_pe);
    endfunction

    // lanes used by the last block, all set when n fills it
    function automatic lane_mask_t edge_mask(input dim_t n);
        lane_mask_t m;
        int         rem;
        rem = int'(n) % n_pe;
        for (int i = 0; i < n_pe; i++) begin
            m[i] = (rem == 0) || (i < rem);
        end
        return m;
    endfunction

endpackage

`default_nettype wire
